//--- link_pkg.sv
package link_pkg;

  // ######################################
  // Link constants
  // ######################################

  localparam int id_w   = 12;  // Node ID width in top of dstaddr
  localparam int addr_w = 32;  // Mesh address width
  localparam int data_w = 32;  // Mesh data width

  // Packets to the local node stay off the link
  localparam logic [id_w-1:0] node_id = 12'h810;

  localparam int pkt_bytes = 13;                // Link bytes per packet
  localparam int byte_w    = 8;                 // Link lane width
  localparam int cnt_w     = $clog2(pkt_bytes); // Byte counter width

  // ######################################
  // Mesh packet
  // ######################################

  // Field order follows the emesh layout with srcaddr on top
  typedef struct packed {
    logic [addr_w-1:0] srcaddr;   // Return address for reads
    logic [data_w-1:0] data;      // Write data
    logic [addr_w-1:0] dstaddr;   // Target whose top id_w bits select node
    logic [3:0]        ctrlmode;  // Passed through untouched
    logic [1:0]        datamode;  // Access size
    logic              write;     // 1 write, 0 read
    logic              access;    // Carried but unused
  } mesh_packet_t;

  // Flat packet width of 104 bits
  localparam int pkt_w = $bits(mesh_packet_t);

  // ######################################
  // Wait pair
  // ######################################

  // Read and write pushback travel together
  typedef struct packed {
    logic rd;  // Read channel stalled
    logic wr;  // Write channel stalled
  } link_wait_t;

endpackage

//--- tx_protocol.sv
`timescale 1ns/1ns

module tx_protocol import link_pkg::*;
(
  input  logic         clk,
  input  logic         reset,

  // System side
  input  logic         etx_access,   // Access strobe
  input  mesh_packet_t etx_packet,
  input  logic         tx_enable,    // Transmit enable level
  output link_wait_t   etx_wait,     // Pushback per access type

  // Asynchronous pushback from far end
  input  link_wait_t   remote_wait,

  // Toward serializer
  output logic         tx_access,
  output mesh_packet_t tx_packet,
  input  logic         io_wait       // Serializer busy
);

  // ######################################
  // Local signals
  // ######################################

  link_wait_t      wait_meta;   // First sync stage
  link_wait_t      wait_sync;   // Clean copy of remote_wait

  logic            pkt_write;   // Access type of offered packet
  logic [id_w-1:0] pkt_dst_id;  // Destination node
  logic            pkt_local;   // Addressed to us
  logic            type_wait;   // Wait bit matching access type
  logic            consumed;    // Taken off the system side this edge
  logic            transmit;    // Consumed and bound for the link

  // ######################################
  // Remote wait synchronizer
  // ######################################

  // Two flops per bit
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wait_meta <= '0;
      wait_sync <= '0;
    end
    else
    begin
      wait_meta <= remote_wait;
      wait_sync <= wait_meta;
    end
  end

  // Serializer stall blocks both types
  assign etx_wait.rd = wait_sync.rd | io_wait;
  assign etx_wait.wr = wait_sync.wr | io_wait;

  // ######################################
  // Packet decode and filter
  // ######################################

  assign pkt_write  = etx_packet.write;
  assign pkt_dst_id = etx_packet.dstaddr[addr_w-1 -: id_w];  // Top bits only
  assign pkt_local  = (pkt_dst_id == node_id);

  // Reads watch rd wait, writes watch wr wait
  assign type_wait = pkt_write ? etx_wait.wr : etx_wait.rd;
  assign consumed  = etx_access & ~type_wait;

  // Disabled or local packets are swallowed
  assign transmit = consumed & tx_enable & ~pkt_local;

  // ######################################
  // Output register
  // ######################################

  // Holds while serializer busy so nothing is dropped
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      tx_access <= 1'b0;
    else if (~io_wait)
      tx_access <= transmit;
  end

  // Payload follows the same enable
  always_ff @(posedge clk)
  begin
    if (~io_wait)
      tx_packet <= etx_packet;
  end

endmodule

//--- tx_serializer.sv
`timescale 1ns/1ns

module tx_serializer import link_pkg::*;
(
  input  logic              clk,
  input  logic              reset,

  // From protocol stage
  input  logic              tx_access,  // Registered packet valid
  input  mesh_packet_t      tx_packet,
  output logic              io_wait,    // Stall back to protocol stage

  // Link lanes
  output logic              lnk_frame,  // High for each packet byte
  output logic [byte_w-1:0] lnk_data
);

  // Index of final byte in a frame
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(pkt_bytes - 1);

  // ######################################
  // Local signals
  // ######################################

  logic [pkt_w-1:0] shift_reg;  // Packet being sent, MSB first
  logic [cnt_w-1:0] byte_cnt;   // Bytes already on the link
  logic             busy;       // Frame in progress

  logic             load;       // Capture a new packet
  logic             last_byte;  // Final byte on the link now

  // Only pick up a packet when idle
  assign load      = tx_access & ~busy;
  assign last_byte = busy & (byte_cnt == last_cnt);

  // ######################################
  // Frame control
  // ######################################

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy     <= 1'b0;
      byte_cnt <= '0;
    end
    else if (load)
    begin
      busy     <= 1'b1;   // First byte goes out next cycle
      byte_cnt <= '0;
    end
    else if (last_byte)
    begin
      busy     <= 1'b0;   // Idle for at least one cycle
      byte_cnt <= '0;
    end
    else if (busy)
      byte_cnt <= byte_cnt + cnt_w'(1);
  end

  // ######################################
  // Byte shifter
  // ######################################

  // Loaded when idle, shifted up while framing
  always_ff @(posedge clk)
  begin
    if (load)
      shift_reg <= tx_packet;
    else if (busy)
      shift_reg <= {shift_reg[pkt_w-byte_w-1:0], {byte_w{1'b0}}};  // Next byte up
  end

  // ######################################
  // Outputs
  // ######################################

  assign io_wait   = busy;   // Straight from the busy flop
  assign lnk_frame = busy;

  // Quiet lane between frames
  assign lnk_data = busy ? shift_reg[pkt_w-1 -: byte_w] : '0;

endmodule

//--- tx_link.sv
`timescale 1ns/1ns

module tx_link import link_pkg::*;
(
  input  logic              clk,
  input  logic              reset,

  // System side
  input  logic              etx_access,
  input  mesh_packet_t      etx_packet,
  input  logic              tx_enable,
  input  link_wait_t        remote_wait,  // Async from far end
  output link_wait_t        etx_wait,

  // Link lanes
  output logic              lnk_frame,
  output logic [byte_w-1:0] lnk_data
);

  // Protocol to serializer
  logic         tx_access;
  mesh_packet_t tx_packet;
  logic         io_wait;     // Serializer busy

  // Filter, sync and register stage
  tx_protocol u_protocol
  (
    .clk         (clk),
    .reset       (reset),
    .etx_access  (etx_access),
    .etx_packet  (etx_packet),
    .tx_enable   (tx_enable),
    .etx_wait    (etx_wait),
    .remote_wait (remote_wait),
    .tx_access   (tx_access),
    .tx_packet   (tx_packet),
    .io_wait     (io_wait)
  );

  // Byte lane driver
  tx_serializer u_serializer
  (
    .clk       (clk),
    .reset     (reset),
    .tx_access (tx_access),
    .tx_packet (tx_packet),
    .io_wait   (io_wait),
    .lnk_frame (lnk_frame),
    .lnk_data  (lnk_data)
  );

endmodule

//--- tb_link_model.svh
`ifndef TB_LINK_MODEL_SVH
`define TB_LINK_MODEL_SVH

// ######################################
// Reference model of the acceptance rule
// ######################################

mesh_packet_t expect_q[$];      // Packets owed to the link, oldest first

link_wait_t   rw_meta = '0;     // Remote waits one edge old
link_wait_t   rw_sync = '0;     // Remote waits two edges old
bit           held_access;      // Packet waiting for the serializer
bit           ser_busy;         // Serializer framing a packet
int           sent_bytes;       // Bytes of the current frame so far

// Node ID lives in the top twelve destination bits
function automatic bit dest_is_local(mesh_packet_t pkt);
  return pkt.dstaddr[31:20] == node_id;
endfunction

// Writes look at the wr wait, reads at rd
function automatic bit type_blocked(mesh_packet_t pkt, link_wait_t w);
  if (pkt.write)
    return w.wr;
  return w.rd;
endfunction

// Synchronized remote waits merged with the serializer stall
function automatic link_wait_t expected_wait();
  link_wait_t w;
  w.rd = rw_sync.rd | ser_busy;
  w.wr = rw_sync.wr | ser_busy;
  return w;
endfunction

// Called with the inputs and wait pair the DUT sees at the next rising edge
// Returns 1 when the packet is owed to the link
function automatic bit accept_offer(bit access, mesh_packet_t pkt, bit enable, link_wait_t w);
  if (!access || type_blocked(pkt, w))
    return 1'b0;             // Nothing consumed this edge
  if (!enable || dest_is_local(pkt))
    return 1'b0;             // Swallowed by the filter
  expect_q.push_back(pkt);
  return 1'b1;
endfunction

// Register and serializer state across one rising edge
task automatic step_pipeline(bit transmit, link_wait_t rw);
  if (ser_busy)
  begin
    sent_bytes++;
    if (sent_bytes == pkt_bytes)
    begin
      ser_busy   = 1'b0;     // Gap edge before the next capture
      sent_bytes = 0;
    end
  end
  else
  begin
    if (held_access)
      ser_busy = 1'b1;       // First byte goes out next cycle
    held_access = transmit;  // Register reloads while not stalled
  end
  rw_sync = rw_meta;
  rw_meta = rw;
endtask

`endif

//--- tb_tx_link.sv
`timescale 1ns/1ns

module tb_tx_link import link_pkg::*;
();

  localparam int clk_period  = 8;
  localparam int reset_cyc   = 16;   // Idle check after reset
  localparam int random_cyc  = 600;
  localparam int wait_cyc    = 600;
  localparam int local_cyc   = 200;
  localparam int disable_cyc = 200;  // Each half of the enable test
  localparam int drain_cyc   = 200;  // Upper bound for the final drain
  localparam int total_cyc   = reset_cyc + random_cyc + wait_cyc + local_cyc
                             + 2 * disable_cyc + drain_cyc + 4;

  logic              clk;
  logic              reset;
  logic              etx_access;
  mesh_packet_t      etx_packet;
  logic              tx_enable;
  link_wait_t        remote_wait;
  link_wait_t        etx_wait;
  logic              lnk_frame;
  logic [byte_w-1:0] lnk_data;

  integer seed = 71;
  int     main_pass;   // Checks in the stimulus process
  int     main_fail;
  int     link_pass;   // Checks in the deserializer
  int     link_fail;
  int     rd_idx;      // Next expected packet in expect_q
  int     fail_mark;   // Failures before the current test

  `include "tb_link_model.svh"

  tx_link uut
  (
    .clk         (clk),
    .reset       (reset),
    .etx_access  (etx_access),
    .etx_packet  (etx_packet),
    .tx_enable   (tx_enable),
    .remote_wait (remote_wait),
    .etx_wait    (etx_wait),
    .lnk_frame   (lnk_frame),
    .lnk_data    (lnk_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Watchdog bound on the whole run
  initial
  begin
    #(total_cyc * 20 * clk_period);
    $display("Watchdog expired, the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  // ######################################
  // Stimulus helpers
  // ######################################

  function automatic logic [31:0] rnd32();
    return $random(seed);
  endfunction

  function automatic mesh_packet_t random_packet(bit force_local);
    mesh_packet_t p;
    logic [31:0]  r;
    p.srcaddr = rnd32();
    p.data    = rnd32();
    p.dstaddr = rnd32();
    r = rnd32();
    p.ctrlmode = r[3:0];
    p.datamode = r[5:4];
    p.write    = r[6];
    p.access   = r[7];    // Ignored by the DUT
    if (force_local)
      p.dstaddr[31:20] = node_id;
    return p;
  endfunction

  // Falling edge drive so the model sees what the next rising edge sees
  task automatic drive_cycle(logic access, mesh_packet_t pkt, logic enable, link_wait_t rw);
    link_wait_t exp_wait;
    bit         owed;
    @(negedge clk);
    etx_access  = access;
    etx_packet  = pkt;
    tx_enable   = enable;
    remote_wait = rw;
    exp_wait = expected_wait();
    assert (etx_wait == exp_wait)
      main_pass++;
    else
    begin
      $display("Error %0t: etx_wait %b expected %b", $time, etx_wait, exp_wait);
      main_fail++;
    end
    owed = accept_offer(access, pkt, enable, exp_wait);
    step_pipeline(owed, rw);
  endtask

  task automatic run_random(int cycles, bit toggle_waits, bit local_dst, logic enable);
    link_wait_t  rw;
    logic [31:0] r;
    rw = '0;
    for (int i = 0; i < cycles; i++)
    begin
      r = rnd32();
      if (toggle_waits && r[4:2] == 3'd0)
        rw = rw ^ r[6:5];   // Occasional flip of the remote pair
      drive_cycle(r[0], random_packet(local_dst && r[8:7] != 2'd0), enable, rw);
    end
  endtask

  task automatic report_test(string name);
    int errs;
    errs = main_fail + link_fail - fail_mark;
    $display("test %s finished, %0d errors, %0d packets queued", name, errs, expect_q.size());
    fail_mark = main_fail + link_fail;
  endtask

  // ######################################
  // Link deserializer and checker
  // ######################################

  task automatic check_frame(logic [pkt_w-1:0] got);
    mesh_packet_t exp_pkt;
    assert (rd_idx < expect_q.size())
    else
    begin
      $display("Unexpected packet on link at %0t, nothing was queued: %h", $time, got);
      link_fail++;
    end
    if (rd_idx < expect_q.size())
    begin
      exp_pkt = expect_q[rd_idx];
      rd_idx++;
      assert (got == exp_pkt)
        link_pass++;
      else
      begin
        $display("Error %0t: packet %0d expected %h observed %h", $time, rd_idx - 1,
                 exp_pkt, got);
        link_fail++;
      end
    end
  endtask

  initial
  begin : deserializer
    logic [pkt_w-1:0] got_bits;
    int               nbytes;
    got_bits = '0;
    nbytes   = 0;
    forever
    begin
      @(negedge clk);   // Link lanes settled mid-cycle
      if (lnk_frame)
      begin
        assert (nbytes != pkt_bytes)
        else
        begin
          $display("Frames overlap at %0t, no idle cycle after a packet", $time);
          link_fail++;
        end
        if (nbytes == pkt_bytes)
          nbytes = 0;
        got_bits = {got_bits[pkt_w-byte_w-1:0], lnk_data};  // MSB byte first
        nbytes++;
        if (nbytes == pkt_bytes)
          check_frame(got_bits);
      end
      else
      begin
        assert (nbytes == 0 || nbytes == pkt_bytes)
        else
        begin
          $display("Frame cut short at %0t after %0d bytes", $time, nbytes);
          link_fail++;
        end
        nbytes = 0;
      end
    end
  end

  // ######################################
  // Test sequence
  // ######################################

  initial
  begin : main_seq
    int q_before;
    int n;
    reset       = 1'b1;
    etx_access  = 1'b0;
    etx_packet  = '0;
    tx_enable   = 1'b0;
    remote_wait = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    // Idle link out of reset
    for (int i = 0; i < reset_cyc; i++)
    begin
      drive_cycle(1'b0, '0, 1'b0, '0);
      assert (lnk_frame == 1'b0 && etx_wait == '0)
        main_pass++;
      else
      begin
        $display("Error %0t: after reset frame %b wait %b, both expected 0", $time, lnk_frame,
                 etx_wait);
        main_fail++;
      end
    end
    report_test("reset_state");

    run_random(random_cyc, 1'b0, 1'b0, 1'b1);
    report_test("random_rw");

    run_random(wait_cyc, 1'b1, 1'b0, 1'b1);   // Remote waits toggling
    report_test("remote_waits");

    run_random(local_cyc, 1'b0, 1'b1, 1'b1);
    report_test("local_dest");

    run_random(disable_cyc, 1'b0, 1'b0, 1'b0);
    q_before = expect_q.size();
    run_random(disable_cyc, 1'b0, 1'b0, 1'b1);  // Enabled again
    assert (rd_idx > q_before)
    else
    begin
      $display("No packet reached the link after transmit was enabled again");
      main_fail++;
    end
    report_test("tx_disable");

    // Idle inputs until the link catches up
    n = 0;
    while ((rd_idx < expect_q.size() || lnk_frame) && n < drain_cyc)
    begin
      drive_cycle(1'b0, '0, 1'b1, '0);
      n++;
    end
    assert (rd_idx == expect_q.size())
      main_pass++;
    else
    begin
      $display("%0d packets missing on link", expect_q.size() - rd_idx);
      main_fail++;
    end
    report_test("drain");

    $display("checks passed %0d, failed %0d", main_pass + link_pass, main_fail + link_fail);
    if (main_fail + link_fail == 0 && link_pass > 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- files.f
+incdir+.
link_pkg.sv
tx_protocol.sv
tx_serializer.sv
tx_link.sv
tb_tx_link.sv

//--- Makefile
# Verilator build and run for the tx_link testbench
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_tx_link
RTL_TOP   ?= tx_link
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= link_pkg.sv tx_protocol.sv tx_serializer.sv tx_link.sv
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
